// ==== files.f ====
+incdir+sim
hw/core_pkg.sv
hw/bridge_settings.sv
hw/cart_loader.sv
hw/pad_mapper.sv
hw/core_top.sv
sim/tb_core_top.sv

// ==== Makefile ====
# Verilator build and run for the core wrapper testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check sim.log"
	@echo "  clean  remove the build directory and sim.log"

test:
	verilator --binary --timing --top-module tb_core_top -f files.f -Mdir obj_dir -o sim_core
	-./obj_dir/sim_core > sim.log 2>&1
	@cat sim.log
	@grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_checks.svh ====
/*
  Compare tasks for the core wrapper testbench: settings,
  memory writes, pad words and single flags, plus failure reporting.
*/

`ifndef tb_checks_svh
`define tb_checks_svh

// print the reason, then stop the run
task automatic report_failure(input string why);
  $display("%s", why);
  $display("Errors found");
  $fatal(1, "simulation stopped");
endtask

task automatic check_settings(input string name, input core_pkg::core_settings_t exp,
                              input core_pkg::core_settings_t act);
  if (act !== exp) begin
    report_failure($sformatf("Error in %s: expected %h, actual %h", name, exp, act));
  end
endtask

task automatic check_mem_write(input string name, input core_pkg::mem_write_t exp,
                               input core_pkg::mem_write_t act);
  if (act !== exp) begin
    report_failure($sformatf("Error in %s: expected addr %h data %h, actual addr %h data %h",
                             name, exp.addr, exp.data, act.addr, act.data));
  end
endtask

task automatic check_pads(input string name, input core_pkg::pad_key_u exp,
                          input core_pkg::pad_key_u act);
  if (act !== exp) begin
    report_failure($sformatf("Error in %s: expected %h, actual %h", name, exp.raw, act.raw));
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    report_failure($sformatf("Error in %s: expected %b, actual %b", name, exp, act));
  end
endtask

`endif

// ==== sim/tb_core_top.sv ====
/*
  Testbench for core_top: clock, reset, bridge stimulus,
  memory responder, reference model and watchdog.
*/

`timescale 1ns/1ns

module tb_core_top;

  localparam int n_setting_writes = 60;
  localparam int n_pad_vectors    = 80;
  localparam int n_cart_words     = 24;
  // settings, button6 toggles, reset, loader and overflow writes
  localparam int n_writes = n_setting_writes + n_pad_vectors / 8 + 2 + n_cart_words
                            + core_pkg::loader_depth + 2;
  localparam longint watchdog_ns = longint'(n_writes * 12 + n_pad_vectors + 500) * 40;

  logic                                        clk_74a;
  logic                                        rst_n;
  core_pkg::bridge_write_t                     bridge;
  core_pkg::pad_key_u [core_pkg::num_pads-1:0] cont_key;
  logic                                        mem_ack;
  core_pkg::core_settings_t                    settings;
  logic                                        core_reset;
  core_pkg::pad_key_u [core_pkg::num_pads-1:0] pads;
  logic                                        mem_req;
  core_pkg::mem_write_t                        mem_cmd;
  logic                                        loader_busy;
  logic                                        loader_overflow;

  core_pkg::core_settings_t model_settings;
  core_pkg::mem_write_t     exp_q[$];
  core_pkg::mem_write_t     seen_q[$];
  logic                     hold_ack;
  logic [31:0] setting_addrs [10] = '{
    core_pkg::addr_turbo_tap, core_pkg::addr_button6, core_pkg::addr_button1_turbo,
    core_pkg::addr_button2_turbo, core_pkg::addr_overscan, core_pkg::addr_extra_sprites,
    core_pkg::addr_raw_rgb, core_pkg::addr_master_boost, core_pkg::addr_adpcm_boost,
    core_pkg::addr_cd_boost};

  `include "tb_checks.svh"

  core_top u_core_top (.*);

  initial begin
    clk_74a = 1'b0;
    forever #20 clk_74a = ~clk_74a;
  end

  initial begin
    #(watchdog_ns);
    report_failure("Watchdog expired: the run hung waiting for the DUT");
  end

  //////////////////////////////////////////////////////////////////////
  // reference model and bridge writes
  //////////////////////////////////////////////////////////////////////

  function automatic core_pkg::core_settings_t next_settings(
    input core_pkg::core_settings_t cur, input logic [31:0] addr, input logic [31:0] data);
    core_pkg::core_settings_t s;
    s = cur;
    case (addr)
      core_pkg::addr_turbo_tap:     s.turbo_tap_enable = data[0];
      core_pkg::addr_button6:       s.button6_enable = data[0];
      core_pkg::addr_button1_turbo: s.button1_turbo_speed = data[1:0];
      core_pkg::addr_button2_turbo: s.button2_turbo_speed = data[1:0];
      core_pkg::addr_overscan:      s.overscan_enable = data[0];
      core_pkg::addr_extra_sprites: s.extra_sprites_enable = data[0];
      core_pkg::addr_raw_rgb:       s.raw_rgb_enable = data[0];
      core_pkg::addr_master_boost:  s.master_audio_boost = data[1:0];
      core_pkg::addr_adpcm_boost:   s.adpcm_audio_boost = data[0];
      core_pkg::addr_cd_boost:      s.cd_audio_boost = data[0];
      default:                      s = cur;
    endcase
    return s;
  endfunction

  // returns just after the edge that samples the write
  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    bridge <= '{wr: 1'b1, addr: addr, data: data};
    @(posedge clk_74a);
    bridge.wr <= 1'b0;
    model_settings = next_settings(model_settings, addr, data);
  endtask

  // big-endian split, high half at the word address
  task automatic cart_write(input logic [31:0] data, input bit kept);
    logic [31:0] addr;
    addr = {core_pkg::cart_region, 28'($urandom)};
    if (kept) begin
      exp_q.push_back('{addr: addr[core_pkg::cart_addr_w-1:0], data: data[31:16]});
      exp_q.push_back('{addr: addr[core_pkg::cart_addr_w-1:0] + 24'd2, data: data[15:0]});
    end
    bridge_write(addr, data);
  endtask

  task automatic expect_reset_high(input int cycles);
    repeat (cycles) begin
      @(negedge clk_74a);
      check_flag("core reset hold", 1'b1, core_reset);
    end
  endtask

  task automatic drain_and_compare(input string name);
    while (seen_q.size() < exp_q.size()) begin
      @(negedge clk_74a);
      check_flag({name, " busy"}, 1'b1, loader_busy);
    end
    while (loader_busy) @(negedge clk_74a);
    check_flag({name, " ack low at idle"}, 1'b0, mem_ack);
    if (seen_q.size() != exp_q.size()) begin
      report_failure($sformatf("Error in %s: expected %0d memory writes, actual %0d",
                               name, exp_q.size(), seen_q.size()));
    end
    foreach (exp_q[i]) check_mem_write(name, exp_q[i], seen_q[i]);
    exp_q.delete();
    seen_q.delete();
  endtask

  //////////////////////////////////////////////////////////////////////
  // memory responder, 0 to 5 cycles of ack delay
  //////////////////////////////////////////////////////////////////////

  initial begin
    core_pkg::mem_write_t got;
    int unsigned          delay;
    mem_ack = 1'b0;
    forever begin
      @(negedge clk_74a);
      if (mem_req && !hold_ack) begin
        delay = $urandom % 6;
        got = mem_cmd;
        repeat (delay) begin
          @(negedge clk_74a);
          check_mem_write("mem_cmd stable under req", got, mem_cmd);
        end
        seen_q.push_back(got);
        @(posedge clk_74a);
        mem_ack <= 1'b1;
        @(negedge clk_74a);
        while (mem_req) @(negedge clk_74a);
        @(posedge clk_74a);
        mem_ack <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]                                 addr;
    core_pkg::pad_key_u [core_pkg::num_pads-1:0] keys;
    core_pkg::pad_key_u                          exp;
    void'($urandom(32'h1f31_280c));
    rst_n = 1'b0;
    bridge = '0;
    cont_key = '0;
    hold_ack = 1'b0;
    model_settings = '0;
    repeat (10) @(posedge clk_74a);
    rst_n <= 1'b1;
    @(negedge clk_74a);
    check_settings("reset settings", '0, settings);
    check_flag("reset core_reset", 1'b0, core_reset);
    check_flag("reset mem_req", 1'b0, mem_req);
    check_flag("reset busy", 1'b0, loader_busy);
    check_flag("reset overflow", 1'b0, loader_overflow);
    for (int p = 0; p < core_pkg::num_pads; p++) check_pads("reset pads", '0, pads[p]);

    // setting writes, one in four to some other non-cartridge address
    for (int i = 0; i < n_setting_writes; i++) begin
      addr = setting_addrs[$urandom % 10];
      if ($urandom % 4 == 0) begin
        addr = $urandom;
        if (addr[31:28] == core_pkg::cart_region) addr[31:28] = 4'h0;
      end
      bridge_write(addr, $urandom);
      @(negedge clk_74a);
      check_settings("settings write", model_settings, settings);
    end

    // second reset write restarts the hold
    bridge_write(core_pkg::addr_core_reset, $urandom);
    expect_reset_high(20);
    bridge_write(core_pkg::addr_core_reset, $urandom);
    expect_reset_high(int'(core_pkg::core_reset_hold));
    @(negedge clk_74a);
    check_flag("core reset release", 1'b0, core_reset);

    for (int i = 0; i < n_pad_vectors; i++) begin
      if (i % 8 == 0) bridge_write(core_pkg::addr_button6, $urandom);
      @(posedge clk_74a);
      for (int p = 0; p < core_pkg::num_pads; p++) keys[p].raw = 16'($urandom);
      cont_key <= keys;
      @(posedge clk_74a);
      @(negedge clk_74a);
      for (int p = 0; p < core_pkg::num_pads; p++) begin
        exp = keys[p];
        if (!model_settings.button6_enable) begin
          exp.btn.face_x = 1'b0;
          exp.btn.face_y = 1'b0;
          exp.btn.trig_l1 = 1'b0;
          exp.btn.trig_r1 = 1'b0;
        end
        check_pads("pad mapping", exp, pads[p]);
      end
    end

    // random gaps, never more words pending than the buffer holds
    for (int i = 0; i < n_cart_words; i++) begin
      repeat ($urandom % 8) @(posedge clk_74a);
      while ((exp_q.size() - seen_q.size() + 1) / 2 >= core_pkg::loader_depth) begin
        @(posedge clk_74a);
      end
      cart_write($urandom, 1'b1);
    end
    drain_and_compare("loader order");
    check_flag("loader no overflow", 1'b0, loader_overflow);

    // one word in the sequencer, loader_depth buffered, the next dropped
    hold_ack <= 1'b1;
    cart_write($urandom, 1'b1);
    while (!mem_req) @(negedge clk_74a);
    repeat (core_pkg::loader_depth) cart_write($urandom, 1'b1);
    @(negedge clk_74a);
    check_flag("overflow at full", 1'b0, loader_overflow);
    cart_write($urandom, 1'b0);
    @(negedge clk_74a);
    check_flag("overflow on drop", 1'b1, loader_overflow);
    hold_ack <= 1'b0;
    drain_and_compare("overflow order");
    check_flag("overflow sticky", 1'b1, loader_overflow);

    $display("No errors");
    $finish;
  end

endmodule

// ==== hw/core_top.sv ====
/*
  Bridge-side core wrapper top: settings registers,
  core reset delay, cartridge loader and pad mapping.
*/

`timescale 1ns/1ns

module core_top (
  input  logic                                        clk_74a,
  input  logic                                        rst_n,

  // host bridge, write side only
  input  core_pkg::bridge_write_t                     bridge,

  // controller key words
  input  core_pkg::pad_key_u [core_pkg::num_pads-1:0] cont_key,

  // cartridge memory write port
  input  logic                                        mem_ack,

  output core_pkg::core_settings_t                    settings,
  output logic                                        core_reset,
  output core_pkg::pad_key_u [core_pkg::num_pads-1:0] pads,
  output logic                                        mem_req,
  output core_pkg::mem_write_t                        mem_cmd,
  output logic                                        loader_busy,
  output logic                                        loader_overflow
);

  //////////////////////////////////////////////////////////////////////
  // settings and core reset
  //////////////////////////////////////////////////////////////////////

  bridge_settings u_bridge_settings (
    .clk_74a    (clk_74a),
    .rst_n      (rst_n),
    .bridge     (bridge),
    .settings   (settings),
    .core_reset (core_reset)
  );

  //////////////////////////////////////////////////////////////////////
  // cartridge data
  //////////////////////////////////////////////////////////////////////

  // decodes the cartridge region itself
  cart_loader u_cart_loader (
    .clk_74a  (clk_74a),
    .rst_n    (rst_n),
    .bridge   (bridge),
    .mem_req  (mem_req),
    .mem_cmd  (mem_cmd),
    .mem_ack  (mem_ack),
    .busy     (loader_busy),
    .overflow (loader_overflow)
  );

  //////////////////////////////////////////////////////////////////////
  // controllers
  //////////////////////////////////////////////////////////////////////

  pad_mapper u_pad_mapper (
    .clk_74a        (clk_74a),
    .rst_n          (rst_n),
    .cont_key       (cont_key),
    .button6_enable (settings.button6_enable),
    .pads           (pads)
  );

endmodule

// ==== hw/pad_mapper.sv ====
/*
  Controller key registration for the console core,
  with the four extra buttons masked off in two-button mode.
*/

`timescale 1ns/1ns

module pad_mapper (
  input  logic                                            clk_74a,
  input  logic                                            rst_n,
  input  core_pkg::pad_key_u [core_pkg::num_pads-1:0]     cont_key,
  input  logic                                            button6_enable,
  output core_pkg::pad_key_u [core_pkg::num_pads-1:0]     pads
);

  core_pkg::pad_key_u [core_pkg::num_pads-1:0] pad_next;

  //////////////////////////////////////////////////////////////////////
  // button masking
  //////////////////////////////////////////////////////////////////////

  // two-button pad hides x, y and the upper shoulder pair
  always_comb begin
    for (int i = 0; i < core_pkg::num_pads; i++) begin
      pad_next[i] = cont_key[i];
      if (!button6_enable) begin
        pad_next[i].btn.face_x  = 1'b0;
        pad_next[i].btn.face_y  = 1'b0;
        pad_next[i].btn.trig_l1 = 1'b0;
        pad_next[i].btn.trig_r1 = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      pads <= '0;
    end else begin
      pads <= pad_next;
    end
  end

endmodule

// ==== hw/cart_loader.sv ====
/*
  Cartridge data loader: buffers bridge words from the cartridge
  region and replays each as two halfword writes, high half first,
  under a four-phase req/ack handshake.
*/

`timescale 1ns/1ns

module cart_loader (
  input  logic                    clk_74a,
  input  logic                    rst_n,
  input  core_pkg::bridge_write_t bridge,
  output logic                    mem_req,
  output core_pkg::mem_write_t    mem_cmd,
  input  logic                    mem_ack,
  output logic                    busy,
  output logic                    overflow
);

  localparam int ptr_w = $clog2(core_pkg::loader_depth);

  // one buffered bridge word
  typedef struct packed {
    logic [core_pkg::cart_addr_w-1:0]   addr;
    logic [core_pkg::bridge_data_w-1:0] data;
  } cart_word_t;

  typedef enum logic [2:0] {
    st_idle,
    st_req_hi,
    st_rel_hi,
    st_req_lo,
    st_rel_lo
  } load_state_t;

  cart_word_t  fifo_mem [core_pkg::loader_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic             push_hit;
  logic             push;
  logic             pop;
  cart_word_t       word_q;
  load_state_t      state;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(core_pkg::loader_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // write buffer
  //////////////////////////////////////////////////////////////////////

  assign push_hit = bridge.wr && (bridge.addr[31:28] == core_pkg::cart_region);
  assign pop      = (state == st_idle) && (count != '0);
  // bridge cannot stall, a full buffer drops the word unless a pop frees a slot
  assign push     = push_hit && ((count != (ptr_w + 1)'(core_pkg::loader_depth)) || pop);

  always_ff @(posedge clk_74a) begin
    if (push) begin
      fifo_mem[wr_ptr] <= '{addr: bridge.addr[core_pkg::cart_addr_w-1:0],
                            data: bridge.data};
    end
  end

  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // sticky until reset
      if (push_hit && !push) begin
        overflow <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // halfword sequencer
  //////////////////////////////////////////////////////////////////////

  // word being replayed, stable for the whole sequence
  always_ff @(posedge clk_74a) begin
    if (pop) begin
      word_q <= fifo_mem[rd_ptr];
    end
  end

  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:   if (pop) state <= st_req_hi;
        st_req_hi: if (mem_ack) state <= st_rel_hi;
        // wait for the memory to drop ack before the next request
        st_rel_hi: if (!mem_ack) state <= st_req_lo;
        st_req_lo: if (mem_ack) state <= st_rel_lo;
        st_rel_lo: if (!mem_ack) state <= st_idle;
        default:   state <= st_idle;
      endcase
    end
  end

  assign mem_req = (state == st_req_hi) || (state == st_req_lo);

  // big-endian bridge, high half at the word address
  always_comb begin
    if (state == st_req_lo || state == st_rel_hi) begin
      mem_cmd.addr = word_q.addr + core_pkg::cart_addr_w'(2);
      mem_cmd.data = word_q.data[core_pkg::half_w-1:0];
    end else begin
      mem_cmd.addr = word_q.addr;
      mem_cmd.data = word_q.data[core_pkg::bridge_data_w-1:core_pkg::half_w];
    end
  end

  assign busy = (count != '0) || (state != st_idle);

endmodule

// ==== hw/bridge_settings.sv ====
/*
  Core settings register block on the bridge bus,
  plus the timed core reset counter.
*/

`timescale 1ns/1ns

module bridge_settings (
  input  logic                       clk_74a,
  input  logic                       rst_n,
  input  core_pkg::bridge_write_t    bridge,
  output core_pkg::core_settings_t   settings,
  output logic                       core_reset
);

  logic [31:0] reset_count;

  //////////////////////////////////////////////////////////////////////
  // option registers
  //////////////////////////////////////////////////////////////////////

  // single-bit options take data[0], speed and boost take data[1:0]
  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      settings <= '0;
    end else if (bridge.wr) begin
      case (bridge.addr)
        core_pkg::addr_turbo_tap: begin
          settings.turbo_tap_enable <= bridge.data[0];
        end
        core_pkg::addr_button6: begin
          settings.button6_enable <= bridge.data[0];
        end
        core_pkg::addr_button1_turbo: begin
          settings.button1_turbo_speed <= bridge.data[1:0];
        end
        core_pkg::addr_button2_turbo: begin
          settings.button2_turbo_speed <= bridge.data[1:0];
        end
        core_pkg::addr_overscan: begin
          settings.overscan_enable <= bridge.data[0];
        end
        core_pkg::addr_extra_sprites: begin
          settings.extra_sprites_enable <= bridge.data[0];
        end
        core_pkg::addr_raw_rgb: begin
          settings.raw_rgb_enable <= bridge.data[0];
        end
        core_pkg::addr_master_boost: begin
          settings.master_audio_boost <= bridge.data[1:0];
        end
        core_pkg::addr_adpcm_boost: begin
          settings.adpcm_audio_boost <= bridge.data[0];
        end
        core_pkg::addr_cd_boost: begin
          settings.cd_audio_boost <= bridge.data[0];
        end
        default: begin
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // core reset delay
  //////////////////////////////////////////////////////////////////////

  // a new reset write restarts the hold, otherwise count down to zero
  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      reset_count <= '0;
    end else if (bridge.wr && bridge.addr == core_pkg::addr_core_reset) begin
      reset_count <= core_pkg::core_reset_hold;
    end else if (reset_count != '0) begin
      reset_count <= reset_count - 32'd1;
    end
  end

  // held for core_reset_hold cycles after the write
  assign core_reset = (reset_count != '0);

endmodule

// ==== hw/core_pkg.sv ====
/*
  Shared definitions for the bridge-side core wrapper:
  bus widths, cartridge region, reset hold, setting addresses,
  bridge write, core settings, pad key and memory write types.
*/

package core_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and sizes
  //////////////////////////////////////////////////////////////////////

  localparam int bridge_addr_w = 32;
  localparam int bridge_data_w = 32;

  // upper address nibble that selects cartridge data
  localparam logic [3:0] cart_region = 4'h1;

  localparam int cart_addr_w  = 24;
  localparam int half_w       = 16;
  localparam int loader_depth = 4;
  localparam int num_pads     = 4;

  // cycles of core reset after a reset word write
  localparam logic [31:0] core_reset_hold = 32'd64;

  //////////////////////////////////////////////////////////////////////
  // setting register addresses
  //////////////////////////////////////////////////////////////////////

  localparam logic [31:0] addr_core_reset     = 32'h0000_0050;

  // input options
  localparam logic [31:0] addr_turbo_tap      = 32'h0000_0100;
  localparam logic [31:0] addr_button6        = 32'h0000_0104;
  localparam logic [31:0] addr_button1_turbo  = 32'h0000_0108;
  localparam logic [31:0] addr_button2_turbo  = 32'h0000_010C;

  // video options
  localparam logic [31:0] addr_overscan       = 32'h0000_0200;
  localparam logic [31:0] addr_extra_sprites  = 32'h0000_0204;
  localparam logic [31:0] addr_raw_rgb        = 32'h0000_0208;

  // audio options
  localparam logic [31:0] addr_master_boost   = 32'h0000_0300;
  localparam logic [31:0] addr_adpcm_boost    = 32'h0000_0304;
  localparam logic [31:0] addr_cd_boost       = 32'h0000_0308;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  // one bridge write cycle, sampled on clk_74a
  typedef struct packed {
    logic                     wr;
    logic [bridge_addr_w-1:0] addr;
    logic [bridge_data_w-1:0] data;
  } bridge_write_t;

  typedef struct packed {
    logic       turbo_tap_enable;
    logic       button6_enable;
    logic [1:0] button1_turbo_speed;
    logic [1:0] button2_turbo_speed;
    logic       overscan_enable;
    logic       extra_sprites_enable;
    logic       raw_rgb_enable;
    logic       cd_audio_boost;
    logic       adpcm_audio_boost;
    logic [1:0] master_audio_boost;
  } core_settings_t;

  // bit 15 first, bit 0 last
  typedef struct packed {
    logic face_start;
    logic face_select;
    logic trig_r3;
    logic trig_l3;
    logic trig_r2;
    logic trig_l2;
    logic trig_r1;
    logic trig_l1;
    logic face_y;
    logic face_x;
    logic face_b;
    logic face_a;
    logic dpad_right;
    logic dpad_left;
    logic dpad_down;
    logic dpad_up;
  } pad_buttons_t;

  // raw key bitmap or named buttons
  typedef union packed {
    logic [15:0]  raw;
    pad_buttons_t btn;
  } pad_key_u;

  typedef struct packed {
    logic [cart_addr_w-1:0] addr;
    logic [half_w-1:0]      data;
  } mem_write_t;

endpackage
